/* design/pic_pkg.sv */
// ==========================================================================
// Shared widths, types and command codes of the single-device PIC core
// Fixed at eight request lines; only single mode with 8086 vectors
// ==========================================================================
package pic_pkg;

    localparam int IRQ_COUNT = 8;

    // One bit per request line
    typedef logic [IRQ_COUNT-1:0]         irq_vec_t;
    typedef logic [$clog2(IRQ_COUNT)-1:0] irq_level_t;
    typedef logic [7:0]                   data_byte_t;
    // T7..T3 of the 8086 vector
    typedef logic [4:0]                   vector_base_t;

    localparam irq_vec_t IMR_RESET_VALUE = '1;

    typedef enum logic [1:0] {READY, WAIT_ICW2, WAIT_ICW4} init_state_t;
    typedef enum logic [1:0] {IDLE, ACK1, ACK2} ack_state_t;
    typedef enum logic [1:0] {READ_IRR, READ_ISR, READ_IMR} rr_sel_t;

    // OCW2 bits 7..5
    localparam logic [2:0] OCW2_NONSPECIFIC_EOI = 3'b001;
    localparam logic [2:0] OCW2_SPECIFIC_EOI    = 3'b011;

    // Flag bits that tell ICW1, OCW2 and OCW3 apart at A0 = 0
    localparam int ICW1_FLAG_BIT = 4;
    localparam int OCW3_FLAG_BIT = 3;

endpackage

/* design/pic_bus_interface.sv */
// ==========================================================================
// CPU bus side: write strobes and the data_out mux
// Write strobes come two clocks after wr_n is sampled high again
// cs_n, a0 and data_in are captured while wr_n is low
// ==========================================================================
`timescale 1ns/100ps

module pic_bus_interface import pic_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       cs_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       a0,
    input  logic       inta_n,
    input  data_byte_t data_in,
    input  irq_vec_t   irr,
    input  irq_vec_t   isr,
    input  irq_vec_t   imr,
    input  rr_sel_t    read_select,
    input  data_byte_t vector,
    input  logic       vector_enable,
    output logic       write_a0_low,
    output logic       write_a0_high,
    output data_byte_t write_data,
    output data_byte_t data_out,
    output logic       data_oe
);

    logic       wr_n_q;
    logic       wr_n_prev;
    logic       cs_n_q;
    logic       a0_q;
    data_byte_t data_q;
    logic       wr_rise;
    logic       read_enable;
    rr_sel_t    read_source;
    data_byte_t read_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_n_q    <= 1'b1;
            wr_n_prev <= 1'b1;
            cs_n_q    <= 1'b1;
            a0_q      <= 1'b0;
        end else begin
            wr_n_q    <= wr_n;
            wr_n_prev <= wr_n_q;
            if (!wr_n) begin
                cs_n_q <= cs_n;
                a0_q   <= a0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!wr_n)
            data_q <= data_in;
    end

    assign wr_rise = wr_n_q & ~wr_n_prev & ~cs_n_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_a0_low  <= 1'b0;
            write_a0_high <= 1'b0;
        end else begin
            write_a0_low  <= wr_rise & ~a0_q;
            write_a0_high <= wr_rise & a0_q;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_rise)
            write_data <= data_q;
    end

    // A0 = 1 always reads the mask
    assign read_source = a0 ? READ_IMR : read_select;

    always_comb begin
        case (read_source)
            READ_ISR: read_data = isr;
            READ_IMR: read_data = imr;
            default:  read_data = irr;
        endcase
    end

    assign read_enable = ~rd_n & ~cs_n & inta_n;

    // Vector wins over readback
    assign data_out = vector_enable ? vector : read_data;
    assign data_oe  = vector_enable | read_enable;

endmodule

/* design/pic_command_registers.sv */
// ==========================================================================
// Initialization sequence and operation command words
// ICW3 is never expected; of ICW4 only AEOI is kept
// OCW words are dropped until the init sequence is complete
// ICW1 clears the mask, AEOI and the read select, as on the 8259
// ==========================================================================
`timescale 1ns/100ps

module pic_command_registers import pic_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         write_a0_low,
    input  logic         write_a0_high,
    input  data_byte_t   write_data,
    output logic         icw1_strobe,
    output logic         level_triggered,
    output logic         auto_eoi,
    output vector_base_t vector_base,
    output irq_vec_t     imr,
    output rr_sel_t      read_select,
    output logic         eoi_nonspecific,
    output logic         eoi_specific,
    output irq_level_t   eoi_level
);

    init_state_t init_state;
    logic        need_icw4;
    logic        ocw_low_write;
    logic        ocw1_write;
    logic        ocw2_write;
    logic        ocw3_write;
    logic        icw2_write;
    logic        icw4_write;

    // Word classification
    assign icw1_strobe   = write_a0_low & write_data[ICW1_FLAG_BIT];
    assign ocw_low_write = write_a0_low & ~write_data[ICW1_FLAG_BIT] & (init_state == READY);
    assign ocw2_write    = ocw_low_write & ~write_data[OCW3_FLAG_BIT];
    assign ocw3_write    = ocw_low_write & write_data[OCW3_FLAG_BIT];
    assign icw2_write    = write_a0_high & (init_state == WAIT_ICW2);
    assign icw4_write    = write_a0_high & (init_state == WAIT_ICW4);
    assign ocw1_write    = write_a0_high & (init_state == READY);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            init_state <= READY;
        end else if (icw1_strobe) begin
            init_state <= WAIT_ICW2;
        end else begin
            case (init_state)
                WAIT_ICW2: if (icw2_write) init_state <= need_icw4 ? WAIT_ICW4 : READY;
                WAIT_ICW4: if (icw4_write) init_state <= READY;
                default:   init_state <= READY;
            endcase
        end
    end

    // ICW1: LTIM and IC4
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            level_triggered <= 1'b0;
            need_icw4       <= 1'b0;
        end else if (icw1_strobe) begin
            level_triggered <= write_data[3];
            need_icw4       <= write_data[0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            vector_base <= '0;
        else if (icw2_write)
            vector_base <= write_data[7:3];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            auto_eoi <= 1'b0;
        else if (icw1_strobe)
            auto_eoi <= 1'b0;
        else if (icw4_write)
            auto_eoi <= write_data[1];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            imr <= IMR_RESET_VALUE;
        else if (icw1_strobe)
            imr <= '0;
        else if (ocw1_write)
            imr <= write_data;
    end

    // OCW3: RR selects, RIS picks ISR over IRR
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            read_select <= READ_IRR;
        else if (icw1_strobe)
            read_select <= READ_IRR;
        else if (ocw3_write && write_data[1])
            read_select <= write_data[0] ? READ_ISR : READ_IRR;
    end

    assign eoi_nonspecific = ocw2_write & (write_data[7:5] == OCW2_NONSPECIFIC_EOI);
    assign eoi_specific    = ocw2_write & (write_data[7:5] == OCW2_SPECIFIC_EOI);
    assign eoi_level       = write_data[2:0];

endmodule

/* design/pic_request_register.sv */
// ==========================================================================
// Interrupt request register
// ir is expected synchronous to clock
// Edge mode holds a request until it is acknowledged or ICW1 is written
// ==========================================================================
`timescale 1ns/100ps

module pic_request_register import pic_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  irq_vec_t   ir,
    input  logic       level_triggered,
    input  logic       icw1_strobe,
    input  logic       latch_in_service,
    input  irq_level_t ack_level,
    output irq_vec_t   irr
);

    irq_vec_t ir_prev;
    irq_vec_t ack_mask;

    assign ack_mask = latch_in_service ? (irq_vec_t'(1) << ack_level) : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ir_prev <= '0;
            irr     <= '0;
        end else begin
            ir_prev <= ir;
            if (icw1_strobe)
                irr <= '0;
            else if (level_triggered)
                irr <= ir & ~ack_mask;
            else
                irr <= (irr | (ir & ~ir_prev)) & ~ack_mask;
        end
    end

endmodule

/* design/pic_priority_service.sv */
// ==========================================================================
// In-service register and fixed priority resolver, IR0 highest
// Fully nested only: a request wins only above every bit in service
// ==========================================================================
`timescale 1ns/100ps

module pic_priority_service import pic_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  irq_vec_t   irr,
    input  irq_vec_t   imr,
    input  logic       icw1_strobe,
    input  logic       latch_in_service,
    input  irq_level_t ack_level,
    input  logic       ack_done,
    input  logic       auto_eoi,
    input  logic       eoi_nonspecific,
    input  logic       eoi_specific,
    input  irq_level_t eoi_level,
    output irq_vec_t   isr,
    output irq_vec_t   winning_request
);

    irq_vec_t pending;
    irq_vec_t pending_top;
    irq_vec_t isr_top;
    irq_vec_t priority_mask;
    irq_vec_t set_mask;
    irq_vec_t clear_mask;

    // Lowest set bit is the highest priority
    assign pending       = irr & ~imr;
    assign pending_top   = pending & (~pending + irq_vec_t'(1));
    assign isr_top       = isr & (~isr + irq_vec_t'(1));

    // Only levels strictly above the top bit in service may win
    assign priority_mask = (isr == '0) ? '1 : (isr_top - irq_vec_t'(1));

    assign winning_request = pending_top & priority_mask;

    assign set_mask = latch_in_service ? (irq_vec_t'(1) << ack_level) : '0;

    always_comb begin
        clear_mask = '0;
        if (eoi_nonspecific)
            clear_mask = clear_mask | isr_top;
        if (eoi_specific)
            clear_mask = clear_mask | (irq_vec_t'(1) << eoi_level);
        if (auto_eoi && ack_done)
            clear_mask = clear_mask | (irq_vec_t'(1) << ack_level);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            isr <= '0;
        else if (icw1_strobe)
            isr <= '0;
        else
            isr <= (isr & ~clear_mask) | set_mask;
    end

endmodule

/* design/pic_ack_control.sv */
// ==========================================================================
// Two-pulse INTA sequence, cpu_int and the 8086 vector
// inta_n is expected synchronous to clock
// An acknowledge with no winner returns IR7 and sets no ISR bit
// ==========================================================================
`timescale 1ns/100ps

module pic_ack_control import pic_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         inta_n,
    input  irq_vec_t     winning_request,
    input  vector_base_t vector_base,
    input  logic         icw1_strobe,
    output logic         cpu_int,
    output logic         latch_in_service,
    output irq_level_t   ack_level,
    output logic         ack_done,
    output data_byte_t   vector,
    output logic         vector_enable
);

    ack_state_t state;
    logic       inta_prev;
    logic       inta_fall;
    logic       inta_rise;

    function automatic irq_level_t encode_level(irq_vec_t onehot);
        irq_level_t level;
        level = irq_level_t'(IRQ_COUNT - 1);
        for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
            if (onehot[i])
                level = irq_level_t'(i);
        end
        return level;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            inta_prev <= 1'b1;
        else
            inta_prev <= inta_n;
    end

    assign inta_fall = inta_prev & ~inta_n;
    assign inta_rise = ~inta_prev & inta_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state            <= IDLE;
            latch_in_service <= 1'b0;
        end else begin
            latch_in_service <= 1'b0;
            if (icw1_strobe) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (inta_fall) begin
                            state            <= ACK1;
                            latch_in_service <= (winning_request != '0);
                        end
                    end
                    ACK1:    if (inta_rise) state <= ACK2;
                    ACK2:    if (inta_rise) state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Level held for the whole sequence
    always_ff @(posedge clock) begin
        if (state == IDLE && inta_fall)
            ack_level <= encode_level(winning_request);
    end

    assign ack_done = (state == ACK2) & inta_rise;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            cpu_int <= 1'b0;
        else if (icw1_strobe || ack_done)
            cpu_int <= 1'b0;
        else if (winning_request != '0)
            cpu_int <= 1'b1;
    end

    assign vector        = {vector_base, ack_level};
    assign vector_enable = (state == ACK2) & ~inta_n;

endmodule

/* design/pic_top.sv */
// ==========================================================================
// Single-device 8259-style interrupt controller, 8086 mode only
// No cascade, buffered mode, poll, rotation or special mask mode
// All bus inputs are expected synchronous to clock
// ==========================================================================
`timescale 1ns/100ps

module pic_top import pic_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       cs_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       a0,
    input  data_byte_t data_in,
    input  irq_vec_t   ir,
    input  logic       inta_n,
    output data_byte_t data_out,
    output logic       data_oe,
    output logic       cpu_int
);

    logic         write_a0_low;
    logic         write_a0_high;
    data_byte_t   write_data;
    logic         icw1_strobe;
    logic         level_triggered;
    logic         auto_eoi;
    vector_base_t vector_base;
    irq_vec_t     imr;
    rr_sel_t      read_select;
    logic         eoi_nonspecific;
    logic         eoi_specific;
    irq_level_t   eoi_level;
    irq_vec_t     irr;
    irq_vec_t     isr;
    irq_vec_t     winning_request;
    logic         latch_in_service;
    irq_level_t   ack_level;
    logic         ack_done;
    data_byte_t   vector;
    logic         vector_enable;

    pic_bus_interface bus_interface_i (
        .clock(clock), .reset(reset), .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .a0(a0),
        .inta_n(inta_n), .data_in(data_in), .irr(irr), .isr(isr), .imr(imr),
        .read_select(read_select), .vector(vector), .vector_enable(vector_enable),
        .write_a0_low(write_a0_low), .write_a0_high(write_a0_high),
        .write_data(write_data), .data_out(data_out), .data_oe(data_oe)
    );

    pic_command_registers command_registers_i (
        .clock(clock), .reset(reset), .write_a0_low(write_a0_low),
        .write_a0_high(write_a0_high), .write_data(write_data),
        .icw1_strobe(icw1_strobe), .level_triggered(level_triggered),
        .auto_eoi(auto_eoi), .vector_base(vector_base), .imr(imr),
        .read_select(read_select), .eoi_nonspecific(eoi_nonspecific),
        .eoi_specific(eoi_specific), .eoi_level(eoi_level)
    );

    pic_request_register request_register_i (
        .clock(clock), .reset(reset), .ir(ir), .level_triggered(level_triggered),
        .icw1_strobe(icw1_strobe), .latch_in_service(latch_in_service),
        .ack_level(ack_level), .irr(irr)
    );

    pic_priority_service priority_service_i (
        .clock(clock), .reset(reset), .irr(irr), .imr(imr), .icw1_strobe(icw1_strobe),
        .latch_in_service(latch_in_service), .ack_level(ack_level), .ack_done(ack_done),
        .auto_eoi(auto_eoi), .eoi_nonspecific(eoi_nonspecific),
        .eoi_specific(eoi_specific), .eoi_level(eoi_level),
        .isr(isr), .winning_request(winning_request)
    );

    pic_ack_control ack_control_i (
        .clock(clock), .reset(reset), .inta_n(inta_n),
        .winning_request(winning_request), .vector_base(vector_base),
        .icw1_strobe(icw1_strobe), .cpu_int(cpu_int),
        .latch_in_service(latch_in_service), .ack_level(ack_level),
        .ack_done(ack_done), .vector(vector), .vector_enable(vector_enable)
    );

endmodule

/* testbench/pic_tb_sva.sv */
// ==========================================================================
// Rules of the INTA sequence checked inside pic_ack_control
// All checks are off while reset is high
// ==========================================================================
`timescale 1ns/100ps

module pic_tb_sva import pic_pkg::*; (
    input logic       clock,
    input logic       reset,
    input ack_state_t state,
    input logic       cpu_int,
    input logic       latch_in_service,
    input logic       ack_done,
    input logic       vector_enable
);

    // Vector only on a second pulse that followed ACK1
    vector_in_ack2: assert property (
        @(posedge clock) disable iff (reset)
            vector_enable |-> (state == ACK2) && ($past(state) != IDLE)
    ) else $error("vector_enable high outside an ACK2 entered from ACK1");

    latch_apart_from_done: assert property (
        @(posedge clock) disable iff (reset) !(latch_in_service && ack_done)
    ) else $error("latch_in_service and ack_done high together");

    cpu_int_drops: assert property (
        @(posedge clock) disable iff (reset) ack_done |=> !cpu_int
    ) else $error("cpu_int still high after ack_done");

endmodule

bind pic_ack_control pic_tb_sva ack_rules_i (
    .clock(clock), .reset(reset), .state(state), .cpu_int(cpu_int),
    .latch_in_service(latch_in_service), .ack_done(ack_done),
    .vector_enable(vector_enable)
);

/* testbench/pic_tb.sv */
// ==========================================================================
// Table-driven testbench for the single-device PIC core
// Inputs change on the rising edge and outputs are sampled on the falling edge
// The run stops at the first mismatch or timeout
// ==========================================================================
`timescale 1ns/100ps

module pic_tb import pic_pkg::*; ();

    typedef enum logic [2:0] {OP_WRITE, OP_SET_IR, OP_CLEAR_IR, OP_ACK, OP_READ} op_t;

    typedef struct packed {
        op_t        op;
        logic       a0;
        data_byte_t data;      // write data or the IR line
        data_byte_t expected;
        logic       cpu_int;
    } row_t;

    localparam int SETTLE_CYCLES  = 4;
    localparam int TIMEOUT_CYCLES = 20;

    logic       clock;
    logic       reset;
    logic       cs_n;
    logic       rd_n;
    logic       wr_n;
    logic       a0;
    data_byte_t data_in;
    irq_vec_t   ir;
    logic       inta_n;
    data_byte_t data_out;
    logic       data_oe;
    logic       cpu_int;
    row_t       rows[$];

    pic_top pic_top_i (
        .clock(clock), .reset(reset), .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .a0(a0),
        .data_in(data_in), .ir(ir), .inta_n(inta_n), .data_out(data_out),
        .data_oe(data_oe), .cpu_int(cpu_int)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_byte_t actual,
                               input data_byte_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%02h, expected 0x%02h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++)
            @(posedge clock);
    endtask

    task automatic wait_for_cpu_int();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (cpu_int !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            cycles++;
            @(negedge clock);
        end
        if (cpu_int !== 1'b1) begin
            $display("Timed out waiting for cpu_int to rise");
            abort_run();
        end
    endtask

    // Bus is idle here, so data_oe must be low
    task automatic check_settled_outputs(input logic expected);
        wait_cycles(SETTLE_CYCLES);
        if (expected)
            wait_for_cpu_int();
        else
            wait_cycles(SETTLE_CYCLES);
        @(negedge clock);
        check_value("cpu_int", {7'b0, cpu_int}, {7'b0, expected});
        check_value("data_oe", {7'b0, data_oe}, 8'h00);
    endtask

    task automatic write_register(input logic addr, input data_byte_t value);
        @(posedge clock);
        cs_n    <= 1'b0;
        a0      <= addr;
        data_in <= value;
        wr_n    <= 1'b0;
        @(posedge clock);
        wr_n <= 1'b1;
        cs_n <= 1'b1;
    endtask

    task automatic read_register(input logic addr, input data_byte_t expected);
        @(posedge clock);
        cs_n <= 1'b0;
        rd_n <= 1'b0;
        a0   <= addr;
        @(negedge clock);
        check_value("data_oe", {7'b0, data_oe}, 8'h01);
        check_value("data_out", data_out, expected);
        @(posedge clock);
        rd_n <= 1'b1;
        cs_n <= 1'b1;
    endtask

    // Two INTA pulses with the vector checked during the second
    task automatic interrupt_ack(input data_byte_t expected);
        @(posedge clock);
        inta_n <= 1'b0;
        wait_cycles(2);
        inta_n <= 1'b1;
        wait_cycles(2);
        inta_n <= 1'b0;
        @(negedge clock);
        check_value("data_oe", {7'b0, data_oe}, 8'h01);
        check_value("data_out", data_out, expected);
        @(posedge clock);
        inta_n <= 1'b1;
    endtask

    task automatic run_row(input row_t row);
        case (row.op)
            OP_WRITE:    write_register(row.a0, row.data);
            OP_READ:     read_register(row.a0, row.expected);
            OP_ACK:      interrupt_ack(row.expected);
            OP_SET_IR: begin
                @(posedge clock);
                ir[row.data[2:0]] <= 1'b1;
            end
            default: begin
                @(posedge clock);
                ir[row.data[2:0]] <= 1'b0;
            end
        endcase
        check_settled_outputs(row.cpu_int);
    endtask

    task automatic add_row(input op_t op, input logic addr, input data_byte_t data,
                           input data_byte_t expected, input logic irq);
        row_t row;
        row = '{op, addr, data, expected, irq};
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row(OP_READ,     1'b1, 8'h00, 8'hFF, 1'b0);
        // Edge mode, ICW2 0x40, ICW4 without AEOI, IR4..IR7 masked
        add_row(OP_WRITE,    1'b0, 8'h13, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'h40, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'h01, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'hF0, 8'h00, 1'b0);
        add_row(OP_SET_IR,   1'b0, 8'h05, 8'h00, 1'b0);
        add_row(OP_SET_IR,   1'b0, 8'h02, 8'h00, 1'b1);
        add_row(OP_ACK,      1'b0, 8'h00, 8'h42, 1'b0);
        add_row(OP_WRITE,    1'b0, 8'h0B, 8'h00, 1'b0);
        add_row(OP_READ,     1'b0, 8'h00, 8'h04, 1'b0);
        add_row(OP_WRITE,    1'b0, 8'h0A, 8'h00, 1'b0);
        add_row(OP_READ,     1'b0, 8'h00, 8'h20, 1'b0);
        // Nesting under IR2
        add_row(OP_SET_IR,   1'b0, 8'h03, 8'h00, 1'b0);
        add_row(OP_SET_IR,   1'b0, 8'h01, 8'h00, 1'b1);
        add_row(OP_ACK,      1'b0, 8'h00, 8'h41, 1'b0);
        add_row(OP_WRITE,    1'b0, 8'h20, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b0, 8'h0B, 8'h00, 1'b0);
        add_row(OP_READ,     1'b0, 8'h00, 8'h04, 1'b0);
        // IR3 is still pending once the ISR is empty
        add_row(OP_WRITE,    1'b0, 8'h62, 8'h00, 1'b1);
        add_row(OP_READ,     1'b0, 8'h00, 8'h00, 1'b1);
        add_row(OP_CLEAR_IR, 1'b0, 8'h01, 8'h00, 1'b1);
        add_row(OP_CLEAR_IR, 1'b0, 8'h02, 8'h00, 1'b1);
        add_row(OP_CLEAR_IR, 1'b0, 8'h03, 8'h00, 1'b1);
        add_row(OP_CLEAR_IR, 1'b0, 8'h05, 8'h00, 1'b1);
        // Level mode with AEOI and only IR6 unmasked
        add_row(OP_WRITE,    1'b0, 8'h1B, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'h40, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'h03, 8'h00, 1'b0);
        add_row(OP_WRITE,    1'b1, 8'hBF, 8'h00, 1'b0);
        add_row(OP_SET_IR,   1'b0, 8'h06, 8'h00, 1'b1);
        add_row(OP_ACK,      1'b0, 8'h00, 8'h46, 1'b1);
        add_row(OP_WRITE,    1'b0, 8'h0B, 8'h00, 1'b1);
        add_row(OP_READ,     1'b0, 8'h00, 8'h00, 1'b1);
    endtask

    initial begin
        reset   = 1'b1;
        cs_n    = 1'b1;
        rd_n    = 1'b1;
        wr_n    = 1'b1;
        a0      = 1'b0;
        data_in = '0;
        ir      = '0;
        inta_n  = 1'b1;
        load_table();
        wait_cycles(10);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++)
            run_row(rows[i]);
        $display("Everything OK");
        $finish;
    end

endmodule

/* src.f */
design/pic_pkg.sv
design/pic_bus_interface.sv
design/pic_command_registers.sv
design/pic_request_register.sv
design/pic_priority_service.sv
design/pic_ack_control.sv
design/pic_top.sv
testbench/pic_tb_sva.sv
testbench/pic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the PIC testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pic_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vpic_tb > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
